//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_tile_binner
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/binner_testdata.txt
# T name e0a e0b e0c e1a e1b e1c e2a e2b e2c min_x min_y tiles_x tiles_y ack_div full_lvl
# ack_div: ack odds 1 in ack_div per cycle, full_lvl: i_full high in full_lvl of 4 cycles
# E x y kind (r raster, s shader) in emit order, D runs the test
T full_cover 1 0 0 0 1 0 -1 -1 400 32 48 3 2 1 2
E 32 48 s
E 48 48 s
E 64 48 s
E 32 64 s
E 48 64 s
E 64 64 s
D
T outside 0 0 -1 0 0 100 0 0 100 64 64 2 1 1 0
D
T half_plane -1 0 40 0 0 1000 0 0 1000 0 0 4 2 3 1
E 0 0 s
E 16 0 s
E 32 0 r
E 0 16 s
E 16 16 s
E 32 16 r
D
T diagonal 1 1 -40 -1 0 63 0 -1 63 0 0 3 3 4 1
E 16 0 r
E 32 0 r
E 0 16 r
E 16 16 r
E 32 16 s
E 0 32 r
E 16 32 s
E 32 32 s
D

//--- dv/tb_tile_binner.sv
// --------------------------------------------------------------------------
// testbench for the tile binner with clock, reset and stimulus read from the
// test data file, plus an output monitor under random back-pressure and report
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_tile_binner import bin_pkg::*; ();

    logic      clk;
    logic      rst_n;
    logic      valid;
    coef_t     coef [9];
    coord_t    min_x;
    coord_t    min_y;
    tile_cnt_t tiles_x;
    tile_cnt_t tiles_y;
    logic      ack_r;
    logic      full;
    coord_t    tile_x;
    coord_t    tile_y;
    logic      valid_r;
    logic      fifo_write;
    logic      busy;

    integer    seed = 32'he8ea;
    int        n_pass;
    int        n_fail;
    int        test_errs;
    logic      aborted;
    string     test_name;
    // nine coefficients, start x/y, tile counts, ack divisor, full level
    int        cfg [15];

    // kind is 1 for raster and 0 for shader
    coord_t    exp_x [$];
    coord_t    exp_y [$];
    logic      exp_kind [$];
    coord_t    got_x [$];
    coord_t    got_y [$];
    logic      got_kind [$];

    always #50 clk = ~clk;

    tile_binner i_tile_binner (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_valid      (valid),
        .i_e0_a       (coef[0]),
        .i_e0_b       (coef[1]),
        .i_e0_c       (coef[2]),
        .i_e1_a       (coef[3]),
        .i_e1_b       (coef[4]),
        .i_e1_c       (coef[5]),
        .i_e2_a       (coef[6]),
        .i_e2_b       (coef[7]),
        .i_e2_c       (coef[8]),
        .i_min_x      (min_x),
        .i_min_y      (min_y),
        .i_tiles_x    (tiles_x),
        .i_tiles_y    (tiles_y),
        .i_ack_r      (ack_r),
        .i_full       (full),
        .o_tile_x     (tile_x),
        .o_tile_y     (tile_y),
        .o_valid_r    (valid_r),
        .o_fifo_write (fifo_write),
        .o_busy       (busy)
    );

    function automatic string kind_name(logic kind);
        return kind ? "raster" : "shader";
    endfunction

    task automatic check_coord(string test, string what, coord_t exp, coord_t act);
        if (exp !== act) begin
            $display("error %s: %s expected %0d actual %0d", test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_strobe_kind(string test, int idx, logic exp, logic act);
        if (exp !== act) begin
            $display("error %s: tile %0d kind expected %s actual %s", test, idx,
                     kind_name(exp), kind_name(act));
            test_errs++;
        end
    endtask

    task automatic check_level(string test, string what, logic exp, logic act);
        if (exp !== act) begin
            $display("error %s: %s expected %b actual %b", test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test(string test);
        if (test_errs == 0) begin
            n_pass++;
            $display("%s: pass", test);
        end else begin
            n_fail++;
            $display("%s: fail, %0d errors", test, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic drive_backpressure();
        ack_r = ({$random(seed)} % cfg[13]) == 0;
        full  = ({$random(seed)} % 4) < cfg[14];
    endtask

    // hands one triangle to the DUT and records every emitted tile
    task automatic run_binning();
        int     cycles;
        int     same_cnt;
        int     full_run;
        int     need;
        logic   hold_r;
        logic   done;
        coord_t prev_x;
        coord_t prev_y;
        cycles = 0;
        while (busy && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("%s: binner still busy before the triangle was sent", test_name);
            test_errs++;
            aborted = 1'b1;
            return;
        end
        @(posedge clk);
        #5;
        foreach (coef[i]) coef[i] = coef_t'(cfg[i]);
        min_x   = coord_t'(cfg[9]);
        min_y   = coord_t'(cfg[10]);
        tiles_x = tile_cnt_t'(cfg[11]);
        tiles_y = tile_cnt_t'(cfg[12]);
        valid   = 1'b1;
        @(posedge clk);
        #5;
        valid    = 1'b0;
        hold_r   = 1'b0;
        done     = 1'b0;
        same_cnt = 0;
        full_run = 0;
        // unlike the first tile, so its age counts from the load
        prev_x   = ~coord_t'(cfg[9]);
        prev_y   = '0;
        cycles   = 0;
        while (!done && cycles < 2000) begin
            @(negedge clk);
            if (!busy) begin
                done = 1'b1;
                if (cycles == 0) begin
                    $display("%s: triangle was not accepted", test_name);
                    test_errs++;
                end
            end else begin
                same_cnt = (tile_x == prev_x && tile_y == prev_y) ? same_cnt + 1 : 0;
                if (hold_r) begin
                    check_level(test_name, "held raster strobe", 1'b1, valid_r);
                    check_coord(test_name, "held tile x", prev_x, tile_x);
                    check_coord(test_name, "held tile y", prev_y, tile_y);
                end
                if (fifo_write && full) begin
                    $display("%s: FIFO written while it was full", test_name);
                    test_errs++;
                end
                // a shader stall cannot reach back past the tile's own queries
                need = (full_run < 9) ? full_run : 9;
                if (fifo_write && same_cnt < need) begin
                    $display("%s: tile moved while the FIFO was full", test_name);
                    test_errs++;
                end
                // decision lands 9 cycles after the tile arrives, any wait after it is a stall
                if (fifo_write && same_cnt - 9 > full_run) begin
                    $display("%s: FIFO write came late after i_full dropped", test_name);
                    test_errs++;
                end
                if (valid_r && ack_r) begin
                    got_x.push_back(tile_x);
                    got_y.push_back(tile_y);
                    got_kind.push_back(1'b1);
                end
                if (fifo_write) begin
                    got_x.push_back(tile_x);
                    got_y.push_back(tile_y);
                    got_kind.push_back(1'b0);
                end
                hold_r   = valid_r && !ack_r;
                full_run = full ? full_run + 1 : 0;
                prev_x   = tile_x;
                prev_y   = tile_y;
                @(posedge clk);
                #5;
                drive_backpressure();
                cycles++;
            end
        end
        if (!done) begin
            $display("%s: timeout, busy never fell after the last tile", test_name);
            test_errs++;
            aborted = 1'b1;
        end
    endtask

    task automatic compare_tiles();
        if (got_x.size() != exp_x.size()) begin
            $display("%s: %0d tiles emitted, %0d expected", test_name, got_x.size(),
                     exp_x.size());
            test_errs++;
        end
        for (int i = 0; i < got_x.size() && i < exp_x.size(); i++) begin
            check_coord(test_name, $sformatf("tile %0d x", i), exp_x[i], got_x[i]);
            check_coord(test_name, $sformatf("tile %0d y", i), exp_y[i], got_y[i]);
            check_strobe_kind(test_name, i, exp_kind[i], got_kind[i]);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    x;
        int    y;
        string line;
        string kind_s;
        clk       = 1'b0;
        rst_n     = 1'b0;
        valid     = 1'b0;
        foreach (coef[i]) coef[i] = '0;
        min_x     = '0;
        min_y     = '0;
        tiles_x   = '0;
        tiles_y   = '0;
        ack_r     = 1'b0;
        full      = 1'b0;
        n_pass    = 0;
        n_fail    = 0;
        test_errs = 0;
        aborted   = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(negedge clk);
        check_level("reset", "o_busy", 1'b0, busy);
        check_level("reset", "o_valid_r", 1'b0, valid_r);
        check_level("reset", "o_fifo_write", 1'b0, fifo_write);
        finish_test("reset");

        fd = $fopen("dv/binner_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file dv/binner_testdata.txt");
            n_fail++;
        end else begin
            while (!aborted && $fgets(line, fd) > 0) begin
                if (line.len() > 0) begin
                    case (line.getc(0))
                        "T": begin
                            n = $sscanf(line, "T %s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                                        test_name, cfg[0], cfg[1], cfg[2], cfg[3], cfg[4],
                                        cfg[5], cfg[6], cfg[7], cfg[8], cfg[9], cfg[10],
                                        cfg[11], cfg[12], cfg[13], cfg[14]);
                            if (n != 16) begin
                                $display("malformed test line in the test data file");
                                test_errs++;
                            end
                        end
                        "E": begin
                            n = $sscanf(line, "E %d %d %s", x, y, kind_s);
                            exp_x.push_back(coord_t'(x));
                            exp_y.push_back(coord_t'(y));
                            exp_kind.push_back(kind_s == "r");
                        end
                        "D": begin
                            run_binning();
                            compare_tiles();
                            finish_test(test_name);
                            exp_x.delete();
                            exp_y.delete();
                            exp_kind.delete();
                            got_x.delete();
                            got_y.delete();
                            got_kind.delete();
                        end
                        default: begin
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- flist.f
hdl/bin_pkg.sv
hdl/edge_query_if.sv
hdl/edge_eval.sv
hdl/tile_walker.sv
hdl/bin_ctrl.sv
hdl/tile_binner.sv
dv/tb_tile_binner.sv

//--- hdl/bin_ctrl.sv
// --------------------------------------------------------------------------
// binner controller: per-tile FSM, six corner queries, sticky
// reject/accept flags and the raster and shader output strobes
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module bin_ctrl import bin_pkg::*; (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_valid,
    input  logic i_ack_r,
    input  logic i_full,
    input  logic i_last,
    output logic o_load,
    output logic o_step,
    output logic o_busy,
    output logic o_valid_r,
    output logic o_fifo_write,
    output logic o_capture,
    edge_query_if.ctrl q_if
);

    bin_state_e state;
    bin_state_e state_nxt;

    logic [2:0] qcnt;
    logic [2:0] res_cnt;
    logic       tr_neg;
    logic       ta_neg;
    logic       accept;

    assign accept = (state == st_idle) && i_valid;

    assign o_capture    = accept;
    assign o_load       = accept;
    assign o_step       = (state == st_step);
    assign o_busy       = (state != st_idle);
    assign o_valid_r    = (state == st_raster_out);
    assign o_fifo_write = (state == st_shader_out) && !i_full;

    // queries 0..2 are TR, 3..5 are TA, same edge order
    assign q_if.query    = (state == st_query);
    assign q_if.corner   = (qcnt < 3'd3) ? corner_tr : corner_ta;
    assign q_if.edge_sel = (qcnt < 3'd3) ? qcnt[1:0] : edge_sel_t'(qcnt - 3'd3);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (i_valid) begin
                    state_nxt = st_query;
                end
            end
            st_query: begin
                if (qcnt == 3'd5) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                // last result lands here, decide next cycle
                if (q_if.res_valid && res_cnt == 3'd5) begin
                    state_nxt = st_decide;
                end
            end
            st_decide: begin
                if (tr_neg) begin
                    state_nxt = i_last ? st_idle : st_step;
                end else if (ta_neg) begin
                    state_nxt = st_raster_out;
                end else begin
                    state_nxt = st_shader_out;
                end
            end
            st_raster_out: begin
                if (i_ack_r) begin
                    state_nxt = i_last ? st_idle : st_step;
                end
            end
            st_shader_out: begin
                if (!i_full) begin
                    state_nxt = i_last ? st_idle : st_step;
                end
            end
            st_step: begin
                state_nxt = st_query;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= st_idle;
            qcnt    <= '0;
            res_cnt <= '0;
            tr_neg  <= 1'b0;
            ta_neg  <= 1'b0;
        end else begin
            state <= state_nxt;

            if (state == st_query) begin
                qcnt <= qcnt + 1'b1;
            end else begin
                qcnt <= '0;
            end

            // fresh tile, nothing in flight at this point
            if (accept || o_step) begin
                res_cnt <= '0;
                tr_neg  <= 1'b0;
                ta_neg  <= 1'b0;
            end else if (q_if.res_valid) begin
                res_cnt <= res_cnt + 1'b1;
                if (res_cnt < 3'd3) begin
                    tr_neg <= tr_neg | q_if.res_neg;
                end else begin
                    ta_neg <= ta_neg | q_if.res_neg;
                end
            end
        end
    end

endmodule

//--- hdl/bin_pkg.sv
// --------------------------------------------------------------------------
// shared widths, tile size and coordinate/coefficient types for the binner
// corner select and controller state enums
// --------------------------------------------------------------------------

package bin_pkg;

    // pixel coordinates are integer, unsigned
    localparam int coord_w   = 12;
    // edge coefficients a, b, c
    localparam int coef_w    = 16;
    // a*x + b*y + c fits with margin
    localparam int efunc_w   = 32;
    localparam int tile_size = 16;
    localparam int cnt_w     = 8;
    localparam int num_edges = 3;

    typedef logic [coord_w-1:0] coord_t;
    typedef logic signed [coef_w-1:0] coef_t;
    typedef logic [cnt_w-1:0] tile_cnt_t;
    typedef logic [1:0] edge_sel_t;

    // trivial reject / trivial accept corner of a tile
    typedef enum logic {
        corner_tr,
        corner_ta
    } corner_e;

    typedef enum logic [2:0] {
        st_idle,
        st_query,
        st_wait,
        st_decide,
        st_raster_out,
        st_shader_out,
        st_step
    } bin_state_e;

endpackage

//--- hdl/edge_eval.sv
// --------------------------------------------------------------------------
// edge evaluator: coefficient store, tile corner select and
// two-stage edge function pipeline returning the sign per query
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module edge_eval import bin_pkg::*; (
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_capture,
    input  coef_t  i_e0_a,
    input  coef_t  i_e0_b,
    input  coef_t  i_e0_c,
    input  coef_t  i_e1_a,
    input  coef_t  i_e1_b,
    input  coef_t  i_e1_c,
    input  coef_t  i_e2_a,
    input  coef_t  i_e2_b,
    input  coef_t  i_e2_c,
    input  coord_t i_tile_x,
    input  coord_t i_tile_y,
    edge_query_if.eval q_if
);

    coef_t coef_a [num_edges];
    coef_t coef_b [num_edges];
    coef_t coef_c [num_edges];

    coef_t a_sel;
    coef_t b_sel;
    logic  x_far;
    logic  y_far;
    logic  signed [coord_w+1:0] cx;
    logic  signed [coord_w+1:0] cy;

    // stage one
    logic  signed [efunc_w-1:0] prod_x;
    logic  signed [efunc_w-1:0] prod_y;
    coef_t c_s1;
    logic  vld_s1;

    logic  signed [efunc_w-1:0] efunc;

    always_ff @(posedge clk) begin
        if (i_capture) begin
            coef_a[0] <= i_e0_a;
            coef_b[0] <= i_e0_b;
            coef_c[0] <= i_e0_c;
            coef_a[1] <= i_e1_a;
            coef_b[1] <= i_e1_b;
            coef_c[1] <= i_e1_c;
            coef_a[2] <= i_e2_a;
            coef_b[2] <= i_e2_b;
            coef_c[2] <= i_e2_c;
        end
    end

    assign a_sel = coef_a[q_if.edge_sel];
    assign b_sel = coef_b[q_if.edge_sel];

    // TR takes the far side where the coefficient is non-negative, TA the other one
    assign x_far = (q_if.corner == corner_ta) ? a_sel[coef_w-1] : !a_sel[coef_w-1];
    assign y_far = (q_if.corner == corner_ta) ? b_sel[coef_w-1] : !b_sel[coef_w-1];

    assign cx = $signed({2'b00, i_tile_x}) + (x_far ? (coord_w+2)'(tile_size) : '0);
    assign cy = $signed({2'b00, i_tile_y}) + (y_far ? (coord_w+2)'(tile_size) : '0);

    always_ff @(posedge clk) begin
        prod_x <= a_sel * cx;
        prod_y <= b_sel * cy;
        c_s1   <= coef_c[q_if.edge_sel];
    end

    assign efunc = prod_x + prod_y + efunc_w'(c_s1);

    always_ff @(posedge clk) begin
        q_if.res_neg <= efunc[efunc_w-1];
    end

    // valid travels alongside the two data stages
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_s1         <= 1'b0;
            q_if.res_valid <= 1'b0;
        end else begin
            vld_s1         <= q_if.query;
            q_if.res_valid <= vld_s1;
        end
    end

endmodule

//--- hdl/edge_query_if.sv
// --------------------------------------------------------------------------
// corner query and sign result channel, controller to edge evaluator
// --------------------------------------------------------------------------

`timescale 1ns/1ps

interface edge_query_if import bin_pkg::*; ();

    // one-cycle request, no back-pressure
    logic      query;
    edge_sel_t edge_sel;
    corner_e   corner;

    // result comes back two cycles after its query
    logic      res_valid;
    logic      res_neg;

    modport ctrl (
        output query,
        output edge_sel,
        output corner,
        input  res_valid,
        input  res_neg
    );

    modport eval (
        input  query,
        input  edge_sel,
        input  corner,
        output res_valid,
        output res_neg
    );

endinterface

//--- hdl/tile_binner.sv
// --------------------------------------------------------------------------
// tile binner top: controller, tile walker and edge evaluator
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tile_binner import bin_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_valid,
    input  coef_t     i_e0_a,
    input  coef_t     i_e0_b,
    input  coef_t     i_e0_c,
    input  coef_t     i_e1_a,
    input  coef_t     i_e1_b,
    input  coef_t     i_e1_c,
    input  coef_t     i_e2_a,
    input  coef_t     i_e2_b,
    input  coef_t     i_e2_c,
    input  coord_t    i_min_x,
    input  coord_t    i_min_y,
    input  tile_cnt_t i_tiles_x,
    input  tile_cnt_t i_tiles_y,
    input  logic      i_ack_r,
    input  logic      i_full,
    output coord_t    o_tile_x,
    output coord_t    o_tile_y,
    output logic      o_valid_r,
    output logic      o_fifo_write,
    output logic      o_busy
);

    logic capture;
    logic load;
    logic step;
    logic last;

    edge_query_if u_query_if ();

    bin_ctrl u_bin_ctrl (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_ack_r      (i_ack_r),
        .i_full       (i_full),
        .i_last       (last),
        .o_load       (load),
        .o_step       (step),
        .o_busy       (o_busy),
        .o_valid_r    (o_valid_r),
        .o_fifo_write (o_fifo_write),
        .o_capture    (capture),
        .q_if         (u_query_if.ctrl)
    );

    // tile position feeds both the evaluator and the output ports
    tile_walker u_tile_walker (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_load    (load),
        .i_step    (step),
        .i_min_x   (i_min_x),
        .i_min_y   (i_min_y),
        .i_tiles_x (i_tiles_x),
        .i_tiles_y (i_tiles_y),
        .o_tile_x  (o_tile_x),
        .o_tile_y  (o_tile_y),
        .o_last    (last)
    );

    edge_eval u_edge_eval (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_capture (capture),
        .i_e0_a    (i_e0_a),
        .i_e0_b    (i_e0_b),
        .i_e0_c    (i_e0_c),
        .i_e1_a    (i_e1_a),
        .i_e1_b    (i_e1_b),
        .i_e1_c    (i_e1_c),
        .i_e2_a    (i_e2_a),
        .i_e2_b    (i_e2_b),
        .i_e2_c    (i_e2_c),
        .i_tile_x  (o_tile_x),
        .i_tile_y  (o_tile_y),
        .q_if      (u_query_if.eval)
    );

endmodule

//--- hdl/tile_walker.sv
// --------------------------------------------------------------------------
// tile walker: current tile position, column and row counters,
// raster order stepping over the grid
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tile_walker import bin_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_load,
    input  logic      i_step,
    input  coord_t    i_min_x,
    input  coord_t    i_min_y,
    input  tile_cnt_t i_tiles_x,
    input  tile_cnt_t i_tiles_y,
    output coord_t    o_tile_x,
    output coord_t    o_tile_y,
    output logic      o_last
);

    coord_t    start_x;
    tile_cnt_t col;
    tile_cnt_t row;
    tile_cnt_t last_col;
    tile_cnt_t last_row;
    logic      row_end;

    assign row_end = (col == last_col);
    assign o_last  = row_end && (row == last_row);

    // only x needs to return to the start, y just keeps climbing
    always_ff @(posedge clk) begin
        if (i_load) begin
            start_x <= i_min_x;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col      <= '0;
            row      <= '0;
            last_col <= '0;
            last_row <= '0;
            o_tile_x <= '0;
            o_tile_y <= '0;
        end else if (i_load) begin
            col      <= '0;
            row      <= '0;
            // zero tiles behaves like a single tile
            last_col <= (i_tiles_x == '0) ? '0 : i_tiles_x - 1'b1;
            last_row <= (i_tiles_y == '0) ? '0 : i_tiles_y - 1'b1;
            o_tile_x <= i_min_x;
            o_tile_y <= i_min_y;
        end else if (i_step) begin
            if (row_end) begin
                col      <= '0;
                row      <= row + 1'b1;
                o_tile_x <= start_x;
                o_tile_y <= o_tile_y + coord_w'(tile_size);
            end else begin
                col      <= col + 1'b1;
                o_tile_x <= o_tile_x + coord_w'(tile_size);
            end
        end
    end

endmodule
